/* common/tensor_pkg.sv */
`default_nettype none

package tensor_pkg;

    ////////////////////////////////////////////////////////////
    // default geometry
    ////////////////////////////////////////////////////////////

    localparam int a_vector_len_default      = 5; // cells in a
    localparam int b_vector_len_default      = 5; // cells in b
    localparam int a_cell_width_default      = 8;
    localparam int b_cell_width_default      = 8;
    localparam int result_cell_width_default = 8;
    localparam int fraction_width_default    = 4; // same for a and b

    // one cell per tile in each direction
    localparam int tiling_v_default = 1;
    localparam int tiling_h_default = 1;

    ////////////////////////////////////////////////////////////
    // derived sizes
    ////////////////////////////////////////////////////////////

    // tiles covering len cells, last one may be partial
    function automatic int tile_count(input int len, input int tile);
        return (len + tile - 1) / tile;
    endfunction

    // bits for an index 0 .. len-1, never below one
    function automatic int index_width(input int len);
        return (len > 1) ? $clog2(len) : 1;
    endfunction

endpackage

`default_nettype wire

/* verilog/operand_sequencer.sv */
`default_nettype none

module operand_sequencer #(
    parameter int A_VECTOR_LEN = tensor_pkg::a_vector_len_default,
    parameter int B_VECTOR_LEN = tensor_pkg::b_vector_len_default,
    parameter int A_CELL_WIDTH = tensor_pkg::a_cell_width_default,
    parameter int B_CELL_WIDTH = tensor_pkg::b_cell_width_default,
    parameter int TILING_V     = tensor_pkg::tiling_v_default,
    parameter int TILING_H     = tensor_pkg::tiling_h_default
) (
    input  logic                                               clk,
    input  logic                                               rst,
    input  logic [A_VECTOR_LEN*A_CELL_WIDTH-1:0]               a,
    input  logic                                               a_valid,
    output logic                                               a_ready,
    input  logic [B_VECTOR_LEN*B_CELL_WIDTH-1:0]               b,
    input  logic                                               b_valid,
    output logic                                               b_ready,
    input  logic                                               collector_busy,
    output logic [TILING_V*A_CELL_WIDTH-1:0]                   tile_a,
    output logic [TILING_H*B_CELL_WIDTH-1:0]                   tile_b,
    output logic [tensor_pkg::index_width(A_VECTOR_LEN)-1:0]   tile_row,
    output logic [tensor_pkg::index_width(B_VECTOR_LEN)-1:0]   tile_col,
    output logic                                               tile_valid,
    output logic                                               tile_last
);

    localparam int ROW_TILES = tensor_pkg::tile_count(A_VECTOR_LEN, TILING_V);
    localparam int COL_TILES = tensor_pkg::tile_count(B_VECTOR_LEN, TILING_H);
    localparam int ROW_CNT_W = tensor_pkg::index_width(ROW_TILES);
    localparam int COL_CNT_W = tensor_pkg::index_width(COL_TILES);
    localparam int ROW_W     = tensor_pkg::index_width(A_VECTOR_LEN);
    localparam int COL_W     = tensor_pkg::index_width(B_VECTOR_LEN);

    logic [A_VECTOR_LEN*A_CELL_WIDTH-1:0] a_hold;
    logic [B_VECTOR_LEN*B_CELL_WIDTH-1:0] b_hold;
    logic                                 a_held;
    logic                                 b_held;
    logic                                 issuing;  // counters walking the tiles
    logic [ROW_CNT_W-1:0]                 row_cnt;
    logic [COL_CNT_W-1:0]                 col_cnt;
    logic                                 row_end;
    logic                                 col_end;
    logic                                 start;
    logic [TILING_V*A_CELL_WIDTH-1:0]     next_tile_a;
    logic [TILING_H*B_CELL_WIDTH-1:0]     next_tile_b;

    assign a_ready = !a_held;
    assign b_ready = !b_held;
    assign row_end = row_cnt == ROW_CNT_W'(ROW_TILES - 1);
    assign col_end = col_cnt == COL_CNT_W'(COL_TILES - 1);

    // both operands in, previous job fully issued and drained
    assign start = a_held && b_held && !issuing && !tile_valid && !collector_busy;

    ////////////////////////////////////////////////////////////
    // operand capture
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (a_valid && a_ready)
            a_hold <= a;
        if (b_valid && b_ready)
            b_hold <= b;
    end

    // held until the last tile has left
    always_ff @(posedge clk) begin
        if (rst) begin
            a_held <= 1'b0;
            b_held <= 1'b0;
        end else begin
            if (a_valid && a_ready)
                a_held <= 1'b1;
            else if (tile_valid && tile_last)
                a_held <= 1'b0;
            if (b_valid && b_ready)
                b_held <= 1'b1;
            else if (tile_valid && tile_last)
                b_held <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // tile walk, row major
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            issuing    <= 1'b0;
            row_cnt    <= '0;
            col_cnt    <= '0;
            tile_valid <= 1'b0;
            tile_last  <= 1'b0;
        end else begin
            tile_valid <= issuing;
            tile_last  <= issuing && row_end && col_end;
            if (start) begin
                issuing <= 1'b1;
                row_cnt <= '0;
                col_cnt <= '0;
            end else if (issuing) begin
                if (col_end) begin
                    col_cnt <= '0;
                    row_cnt <= row_cnt + 1'b1;
                    if (row_end)
                        issuing <= 1'b0; // last tile goes out now
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
        end
    end

    // slice held vectors, zero past the vector end
    always_comb begin
        for (int v = 0; v < TILING_V; v++) begin
            if (int'(row_cnt) * TILING_V + v < A_VECTOR_LEN)
                next_tile_a[v*A_CELL_WIDTH +: A_CELL_WIDTH] =
                    a_hold[(int'(row_cnt) * TILING_V + v) * A_CELL_WIDTH +: A_CELL_WIDTH];
            else
                next_tile_a[v*A_CELL_WIDTH +: A_CELL_WIDTH] = '0;
        end
        for (int h = 0; h < TILING_H; h++) begin
            if (int'(col_cnt) * TILING_H + h < B_VECTOR_LEN)
                next_tile_b[h*B_CELL_WIDTH +: B_CELL_WIDTH] =
                    b_hold[(int'(col_cnt) * TILING_H + h) * B_CELL_WIDTH +: B_CELL_WIDTH];
            else
                next_tile_b[h*B_CELL_WIDTH +: B_CELL_WIDTH] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (issuing) begin
            tile_a   <= next_tile_a;
            tile_b   <= next_tile_b;
            tile_row <= ROW_W'(int'(row_cnt) * TILING_V); // base cell, not tile number
            tile_col <= COL_W'(int'(col_cnt) * TILING_H);
        end
    end

endmodule

`default_nettype wire

/* verilog/product_cell.sv */
`default_nettype none

module product_cell #(
    parameter int A_CELL_WIDTH      = tensor_pkg::a_cell_width_default,
    parameter int B_CELL_WIDTH      = tensor_pkg::b_cell_width_default,
    parameter int RESULT_CELL_WIDTH = tensor_pkg::result_cell_width_default,
    parameter int FRACTION_WIDTH    = tensor_pkg::fraction_width_default
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [A_CELL_WIDTH-1:0]      a_value,
    input  logic [B_CELL_WIDTH-1:0]      b_value,
    output logic [RESULT_CELL_WIDTH-1:0] product,
    output logic                         overflow
);

    localparam int PROD_W = A_CELL_WIDTH + B_CELL_WIDTH;
    // wide enough for the full product and the kept result
    localparam int FULL_W = (PROD_W > RESULT_CELL_WIDTH) ? PROD_W : RESULT_CELL_WIDTH;

    logic signed [FULL_W-1:0] full;
    logic                     fits;

    // operands sign extend to FULL_W before the multiply
    assign full = ($signed(a_value) * $signed(b_value)) >>> FRACTION_WIDTH;

    // dropped bits must all equal the kept sign bit
    assign fits = (&full[FULL_W-1:RESULT_CELL_WIDTH-1]) || !(|full[FULL_W-1:RESULT_CELL_WIDTH-1]);

    always_ff @(posedge clk) begin
        product <= full[RESULT_CELL_WIDTH-1:0]; // wraps
    end

    always_ff @(posedge clk) begin
        if (rst)
            overflow <= 1'b0;
        else
            overflow <= !fits;
    end

endmodule

`default_nettype wire

/* verilog/result_collector.sv */
`default_nettype none

module result_collector #(
    parameter int A_VECTOR_LEN      = tensor_pkg::a_vector_len_default,
    parameter int B_VECTOR_LEN      = tensor_pkg::b_vector_len_default,
    parameter int RESULT_CELL_WIDTH = tensor_pkg::result_cell_width_default,
    parameter int TILING_V          = tensor_pkg::tiling_v_default,
    parameter int TILING_H          = tensor_pkg::tiling_h_default
) (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  logic [tensor_pkg::index_width(A_VECTOR_LEN)-1:0]     tile_row,
    input  logic [tensor_pkg::index_width(B_VECTOR_LEN)-1:0]     tile_col,
    input  logic                                                 tile_valid,
    input  logic                                                 tile_last,
    input  logic [TILING_V*TILING_H*RESULT_CELL_WIDTH-1:0]       cell_products,
    input  logic [TILING_V*TILING_H-1:0]                         cell_overflows,
    output logic [A_VECTOR_LEN*B_VECTOR_LEN*RESULT_CELL_WIDTH-1:0] result,
    output logic                                                 result_valid,
    input  logic                                                 result_ready,
    output logic                                                 error,
    output logic                                                 collector_busy
);

    localparam int TILE_CELLS = TILING_V * TILING_H;
    localparam int ROW_W      = tensor_pkg::index_width(A_VECTOR_LEN);
    localparam int COL_W      = tensor_pkg::index_width(B_VECTOR_LEN);

    logic                  valid_d;
    logic                  last_d;
    logic [ROW_W-1:0]      row_d;
    logic [COL_W-1:0]      col_d;
    logic                  busy_q;
    logic                  first_tile;
    logic [TILE_CELLS-1:0] in_range; // grid position inside the matrix

    assign first_tile     = valid_d && !busy_q;
    assign collector_busy = busy_q || valid_d;

    ////////////////////////////////////////////////////////////
    // tile position, aligned with the cell registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_d <= 1'b0;
            last_d  <= 1'b0;
        end else begin
            valid_d <= tile_valid;
            last_d  <= tile_valid && tile_last;
        end
    end

    always_ff @(posedge clk) begin
        row_d <= tile_row;
        col_d <= tile_col;
    end

    always_comb begin
        for (int v = 0; v < TILING_V; v++) begin
            for (int h = 0; h < TILING_H; h++) begin
                in_range[v*TILING_H + h] = (int'(row_d) + v < A_VECTOR_LEN) &&
                                           (int'(col_d) + h < B_VECTOR_LEN);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // matrix write
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (valid_d) begin
            for (int v = 0; v < TILING_V; v++) begin
                for (int h = 0; h < TILING_H; h++) begin
                    if (in_range[v*TILING_H + h])
                        result[((int'(row_d) + v) * B_VECTOR_LEN + int'(col_d) + h)
                               * RESULT_CELL_WIDTH +: RESULT_CELL_WIDTH] <=
                            cell_products[(v*TILING_H + h)*RESULT_CELL_WIDTH +: RESULT_CELL_WIDTH];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // error flag and result handshake
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q       <= 1'b0;
            result_valid <= 1'b0;
            error        <= 1'b0;
        end else begin
            if (valid_d) begin
                busy_q <= 1'b1;
                // sticky within a job, fresh on its first tile
                error  <= (error && !first_tile) || |(cell_overflows & in_range);
                if (last_d)
                    result_valid <= 1'b1;
            end else if (result_valid && result_ready) begin
                result_valid <= 1'b0;
                busy_q       <= 1'b0; // lets the sequencer start again
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/tensor_product.sv */
`default_nettype none

module tensor_product #(
    parameter int A_VECTOR_LEN      = tensor_pkg::a_vector_len_default,
    parameter int B_VECTOR_LEN      = tensor_pkg::b_vector_len_default,
    parameter int A_CELL_WIDTH      = tensor_pkg::a_cell_width_default,
    parameter int B_CELL_WIDTH      = tensor_pkg::b_cell_width_default,
    parameter int RESULT_CELL_WIDTH = tensor_pkg::result_cell_width_default,
    parameter int FRACTION_WIDTH    = tensor_pkg::fraction_width_default,
    parameter int TILING_V          = tensor_pkg::tiling_v_default,
    parameter int TILING_H          = tensor_pkg::tiling_h_default
) (
    input  logic                                                  clk,
    input  logic                                                  rst,
    input  logic [A_VECTOR_LEN*A_CELL_WIDTH-1:0]                  a,
    input  logic                                                  a_valid,
    output logic                                                  a_ready,
    input  logic [B_VECTOR_LEN*B_CELL_WIDTH-1:0]                  b,
    input  logic                                                  b_valid,
    output logic                                                  b_ready,
    output logic [A_VECTOR_LEN*B_VECTOR_LEN*RESULT_CELL_WIDTH-1:0] result,
    output logic                                                  result_valid,
    input  logic                                                  result_ready,
    output logic                                                  error
);

    localparam int ROW_W = tensor_pkg::index_width(A_VECTOR_LEN);
    localparam int COL_W = tensor_pkg::index_width(B_VECTOR_LEN);

    logic [TILING_V*A_CELL_WIDTH-1:0]               tile_a;
    logic [TILING_H*B_CELL_WIDTH-1:0]               tile_b;
    logic [ROW_W-1:0]                               tile_row;
    logic [COL_W-1:0]                               tile_col;
    logic                                           tile_valid;
    logic                                           tile_last;
    logic                                           collector_busy;
    logic [TILING_V*TILING_H*RESULT_CELL_WIDTH-1:0] cell_products; // cell (v,h) at v*TILING_H+h
    logic [TILING_V*TILING_H-1:0]                   cell_overflows;

    operand_sequencer #(
        .A_VECTOR_LEN (A_VECTOR_LEN),
        .B_VECTOR_LEN (B_VECTOR_LEN),
        .A_CELL_WIDTH (A_CELL_WIDTH),
        .B_CELL_WIDTH (B_CELL_WIDTH),
        .TILING_V     (TILING_V),
        .TILING_H     (TILING_H)
    ) i_operand_sequencer (
        .clk            (clk),
        .rst            (rst),
        .a              (a),
        .a_valid        (a_valid),
        .a_ready        (a_ready),
        .b              (b),
        .b_valid        (b_valid),
        .b_ready        (b_ready),
        .collector_busy (collector_busy),
        .tile_a         (tile_a),
        .tile_b         (tile_b),
        .tile_row       (tile_row),
        .tile_col       (tile_col),
        .tile_valid     (tile_valid),
        .tile_last      (tile_last)
    );

    // product grid, one multiplier per tile position
    for (genvar v = 0; v < TILING_V; v++) begin : g_row
        for (genvar h = 0; h < TILING_H; h++) begin : g_col
            product_cell #(
                .A_CELL_WIDTH      (A_CELL_WIDTH),
                .B_CELL_WIDTH      (B_CELL_WIDTH),
                .RESULT_CELL_WIDTH (RESULT_CELL_WIDTH),
                .FRACTION_WIDTH    (FRACTION_WIDTH)
            ) i_product_cell (
                .clk      (clk),
                .rst      (rst),
                .a_value  (tile_a[v*A_CELL_WIDTH +: A_CELL_WIDTH]),
                .b_value  (tile_b[h*B_CELL_WIDTH +: B_CELL_WIDTH]),
                .product  (cell_products[(v*TILING_H + h)*RESULT_CELL_WIDTH +: RESULT_CELL_WIDTH]),
                .overflow (cell_overflows[v*TILING_H + h])
            );
        end
    end

    result_collector #(
        .A_VECTOR_LEN      (A_VECTOR_LEN),
        .B_VECTOR_LEN      (B_VECTOR_LEN),
        .RESULT_CELL_WIDTH (RESULT_CELL_WIDTH),
        .TILING_V          (TILING_V),
        .TILING_H          (TILING_H)
    ) i_result_collector (
        .clk            (clk),
        .rst            (rst),
        .tile_row       (tile_row),
        .tile_col       (tile_col),
        .tile_valid     (tile_valid),
        .tile_last      (tile_last),
        .cell_products  (cell_products),
        .cell_overflows (cell_overflows),
        .result         (result),
        .result_valid   (result_valid),
        .result_ready   (result_ready),
        .error          (error),
        .collector_busy (collector_busy)
    );

endmodule

`default_nettype wire

/* tb/tensor_product_assert.sv */
`default_nettype none

module tensor_product_assert #(
    parameter int RESULT_W = 200
) (
    input logic                clk,
    input logic                rst,
    input logic [RESULT_W-1:0] result,
    input logic                result_valid,
    input logic                result_ready,
    input logic                error,
    input logic                a_ready,
    input logic                b_ready
);

    ////////////////////////////////////////////////////////////
    // result stalls
    ////////////////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (rst)
        result_valid && !result_ready |=> result_valid)
        else $error("result_valid dropped before result_ready");

    assert property (@(posedge clk) disable iff (rst)
        result_valid && !result_ready |=> $stable(result) && $stable(error))
        else $error("result or error changed while stalled");

    // both operand ports open right out of reset
    assert property (@(posedge clk) $fell(rst) |-> a_ready && b_ready)
        else $error("operand ready low after reset");

endmodule

bind tensor_product tensor_product_assert #(
    .RESULT_W (A_VECTOR_LEN * B_VECTOR_LEN * RESULT_CELL_WIDTH)
) i_tensor_product_assert (
    .clk          (clk),
    .rst          (rst),
    .result       (result),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .error        (error),
    .a_ready      (a_ready),
    .b_ready      (b_ready)
);

`default_nettype wire

/* tb/tensor_product_tb.sv */
`default_nettype none

module tensor_product_tb;

    localparam int A_LEN       = 5;
    localparam int B_LEN       = 5;
    localparam int TILE_V      = 2;
    localparam int TILE_H      = 2;
    localparam int AW          = tensor_pkg::a_cell_width_default;
    localparam int BW          = tensor_pkg::b_cell_width_default;
    localparam int RW          = tensor_pkg::result_cell_width_default;
    localparam int FW          = tensor_pkg::fraction_width_default;
    localparam int RES_W       = A_LEN * B_LEN * RW;
    localparam int TILES       = tensor_pkg::tile_count(A_LEN, TILE_V) *
                                 tensor_pkg::tile_count(B_LEN, TILE_H);
    localparam int LATENCY     = TILES + 3; // acceptance edge to result_valid
    localparam int JOB_COUNT   = 28;
    localparam int MAX_STALL   = 8;
    localparam int CYCLE_LIMIT = 16 + JOB_COUNT * (LATENCY + MAX_STALL + 10) + 100;
    localparam int DRIVE_DELAY = 2;

    logic                  clk;
    logic                  rst;
    logic [A_LEN*AW-1:0]   a;
    logic                  a_valid;
    logic                  a_ready;
    logic [B_LEN*BW-1:0]   b;
    logic                  b_valid;
    logic                  b_ready;
    logic [RES_W-1:0]      result;
    logic                  result_valid;
    logic                  result_ready;
    logic                  error;

    int cycle;
    int error_count;
    int check_count;
    int seed;

    tensor_product #(
        .A_VECTOR_LEN (A_LEN),
        .B_VECTOR_LEN (B_LEN),
        .TILING_V     (TILE_V),
        .TILING_H     (TILE_H)
    ) i_tensor_product (
        .clk          (clk),
        .rst          (rst),
        .a            (a),
        .a_valid      (a_valid),
        .a_ready      (a_ready),
        .b            (b),
        .b_valid      (b_valid),
        .b_ready      (b_ready),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .error        (error)
    );

    always #20 clk = ~clk;

    // cycle count, also the run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("run stopped, no completion within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // reference model and checks
    ////////////////////////////////////////////////////////////

    // shift right by the fraction, keep low bits, flag values out of range
    function automatic void expected_product(input logic [A_LEN*AW-1:0] av,
                                             input logic [B_LEN*BW-1:0] bv,
                                             output logic [RES_W-1:0] res,
                                             output logic err);
        int x;
        int y;
        int p;
        res = '0;
        err = 1'b0;
        for (int r = 0; r < A_LEN; r++) begin
            for (int c = 0; c < B_LEN; c++) begin
                x = $signed(av[r*AW +: AW]);
                y = $signed(bv[c*BW +: BW]);
                p = (x * y) >>> FW;
                if (p >= (1 << (RW - 1)) || p < -(1 << (RW - 1)))
                    err = 1'b1;
                res[(r*B_LEN + c)*RW +: RW] = p[RW-1:0];
            end
        end
    endfunction

    task automatic report_mismatch(input string msg);
        $display("Fail %0t: %s", $time, msg);
        error_count++;
    endtask

    task automatic compare_result(input logic [RES_W-1:0] exp_res, input logic exp_err);
        logic [RW-1:0] got;
        logic [RW-1:0] want;
        for (int r = 0; r < A_LEN; r++) begin
            for (int c = 0; c < B_LEN; c++) begin
                got  = result[(r*B_LEN + c)*RW +: RW];
                want = exp_res[(r*B_LEN + c)*RW +: RW];
                check_count++;
                if (got !== want)
                    report_mismatch($sformatf("cell (%0d,%0d) is %h, expected %h",
                                              r, c, got, want));
            end
        end
        check_count++;
        if (error !== exp_err)
            report_mismatch($sformatf("error is %b, expected %b", error, exp_err));
    endtask

    ////////////////////////////////////////////////////////////
    // handshakes
    ////////////////////////////////////////////////////////////

    task automatic send_a(input logic [A_LEN*AW-1:0] vec, output int accept_cycle);
        a       = vec;
        a_valid = 1'b1;
        @(negedge clk);
        while (!a_ready)
            @(negedge clk);
        accept_cycle = cycle + 1; // taken on the coming edge
        @(posedge clk);
        #DRIVE_DELAY;
        a_valid = 1'b0;
    endtask

    task automatic send_b(input logic [B_LEN*BW-1:0] vec, output int accept_cycle);
        b       = vec;
        b_valid = 1'b1;
        @(negedge clk);
        while (!b_ready)
            @(negedge clk);
        accept_cycle = cycle + 1;
        @(posedge clk);
        #DRIVE_DELAY;
        b_valid = 1'b0;
    endtask

    // order 0 together, 1 a first, 2 b first
    task automatic send_both(input logic [A_LEN*AW-1:0] av, input logic [B_LEN*BW-1:0] bv,
                             input int order, input int gap, output int accept_cycle);
        int ta;
        int tb;
        if (order == 0) begin
            fork
                send_a(av, ta);
                send_b(bv, tb);
            join
        end else if (order == 1) begin
            send_a(av, ta);
            repeat (gap) @(posedge clk);
            #DRIVE_DELAY;
            send_b(bv, tb);
        end else begin
            send_b(bv, tb);
            repeat (gap) @(posedge clk);
            #DRIVE_DELAY;
            send_a(av, ta);
        end
        accept_cycle = (ta > tb) ? ta : tb; // the later one starts the job
    endtask

    task automatic check_result(input logic [A_LEN*AW-1:0] av, input logic [B_LEN*BW-1:0] bv,
                                input int start_cycle, input int stall, output int take_cycle);
        logic [RES_W-1:0] exp_res;
        logic             exp_err;
        expected_product(av, bv, exp_res, exp_err);
        result_ready = (stall == 0);
        @(negedge clk);
        while (!result_valid)
            @(negedge clk);
        check_count++;
        if (cycle - start_cycle != LATENCY)
            report_mismatch($sformatf("result_valid after %0d cycles, expected %0d",
                                      cycle - start_cycle, LATENCY));
        compare_result(exp_res, exp_err);
        for (int k = 0; k < stall; k++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (k == stall - 1)
                result_ready = 1'b1;
            @(negedge clk);
            check_count++;
            if (!result_valid)
                report_mismatch("result_valid dropped while result_ready low");
            compare_result(exp_res, exp_err); // must hold through the stall
        end
        take_cycle = cycle + 1;
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic random_operands(output logic [A_LEN*AW-1:0] av,
                                   output logic [B_LEN*BW-1:0] bv);
        for (int i = 0; i < A_LEN; i++)
            av[i*AW +: AW] = $random(seed);
        for (int i = 0; i < B_LEN; i++)
            bv[i*BW +: BW] = $random(seed);
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_basic();
        int acc;
        int take;
        send_both(40'h50_40_30_20_10, 40'h05_04_03_02_01, 0, 0, acc);
        check_result(40'h50_40_30_20_10, 40'h05_04_03_02_01, acc, 0, take);
    endtask

    task automatic test_order();
        int acc;
        int take;
        send_both(40'h1c_f0_33_08_e5, 40'h0a_fe_21_17_f9, 2, 4, acc); // b early
        check_result(40'h1c_f0_33_08_e5, 40'h0a_fe_21_17_f9, acc, 0, take);
        send_both(40'h2d_06_c1_7a_11, 40'he4_35_09_f2_40, 1, 3, acc);
        check_result(40'h2d_06_c1_7a_11, 40'he4_35_09_f2_40, acc, 0, take);
    endtask

    // mixed signs, fraction bits set, all in range
    task automatic test_fraction();
        int acc;
        int take;
        send_both(40'he1_19_d8_27_f3, 40'h11_d7_0f_fa_2b, 0, 0, acc);
        check_result(40'he1_19_d8_27_f3, 40'h11_d7_0f_fa_2b, acc, 0, take);
    endtask

    // only cell (4,4) overflows, in the partial corner tile
    task automatic test_overflow();
        int acc;
        int take;
        send_both(40'h7f_02_02_02_02, 40'h7f_03_03_03_03, 0, 0, acc);
        check_result(40'h7f_02_02_02_02, 40'h7f_03_03_03_03, acc, 0, take);
        send_both(40'h50_40_30_20_10, 40'h05_04_03_02_01, 0, 0, acc);
        check_result(40'h50_40_30_20_10, 40'h05_04_03_02_01, acc, 0, take);
    endtask

    task automatic test_backpressure();
        logic [A_LEN*AW-1:0] a1;
        logic [B_LEN*BW-1:0] b1;
        logic [A_LEN*AW-1:0] a2;
        logic [B_LEN*BW-1:0] b2;
        int                  acc1;
        int                  acc2;
        int                  take1;
        int                  take2;
        int                  stall;
        random_operands(a1, b1);
        random_operands(a2, b2);
        stall = 2 + ($unsigned($random(seed)) % (MAX_STALL - 1));
        send_both(a1, b1, 0, 0, acc1);
        fork
            check_result(a1, b1, acc1, stall, take1);
            begin
                @(posedge clk);
                #DRIVE_DELAY;
                while (!result_valid) begin
                    @(posedge clk);
                    #DRIVE_DELAY;
                end
                send_both(a2, b2, 0, 0, acc2); // while the first result waits
            end
        join
        check_count++;
        if (acc2 >= take1)
            report_mismatch("next operands were not accepted during the stall");
        check_result(a2, b2, take1, 0, take2);
    endtask

    task automatic test_random();
        logic [A_LEN*AW-1:0] av;
        logic [B_LEN*BW-1:0] bv;
        int                  acc;
        int                  take;
        int                  stall;
        for (int j = 0; j < 20; j++) begin
            random_operands(av, bv);
            stall = $unsigned($random(seed)) % (MAX_STALL + 1);
            send_both(av, bv, 0, 0, acc);
            check_result(av, bv, acc, stall, take);
        end
    endtask

    initial begin
        seed         = 32'he9136788;
        cycle        = 0;
        error_count  = 0;
        check_count  = 0;
        clk          = 1'b0;
        rst          = 1'b1;
        a            = '0;
        a_valid      = 1'b0;
        b            = '0;
        b_valid      = 1'b0;
        result_ready = 1'b1;
        repeat (16) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        test_basic();
        test_order();
        test_fraction();
        test_overflow();
        test_backpressure();
        test_random();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tensor_product.f */
common/tensor_pkg.sv
verilog/operand_sequencer.sv
verilog/product_cell.sv
verilog/result_collector.sv
verilog/tensor_product.sv
tb/tensor_product_assert.sv
tb/tensor_product_tb.sv
